// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= recovery_rx_tb
FILELIST  ?= recovery_rx_top.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= No errors

SOURCES := $(wildcard hw/*.sv hw/*.svh tb/*.sv)
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The run passes only when the pass line shows up in the output
run: $(SIM)
	@out="$$(./$(SIM) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== hw/recovery_defines.svh ====
`ifndef RECOVERY_DEFINES_SVH
`define RECOVERY_DEFINES_SVH

// Bytes per packed output word
`define RECOVERY_WORD_BYTES 4

// Queue depths
`define RECOVERY_BYTE_FIFO_DEPTH 8
`define RECOVERY_WORD_FIFO_DEPTH 4

// SMBus style PEC, x^8 + x^2 + x + 1
`define RECOVERY_PEC_POLY 8'h07

`endif

// ==== hw/recovery_fifo.sv ====
`timescale 1ns/1ns

module recovery_fifo #(
  parameter type payload_t = logic [7:0],
  parameter int unsigned Depth = 4
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     push_i,
  input  payload_t data_i,
  input  logic     pop_i,
  output logic     full_o,
  output logic     empty_o,
  output payload_t data_o
);

  localparam int unsigned PtrW = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntW = $clog2(Depth + 1);

  payload_t            mem_q [Depth];
  logic     [PtrW-1:0] wr_ptr_q;
  logic     [PtrW-1:0] rd_ptr_q;
  logic     [CntW-1:0] count_q;
  logic                do_push;
  logic                do_pop;

  assign full_o  = (count_q == CntW'(Depth));
  assign empty_o = (count_q == '0);
  assign data_o  = mem_q[rd_ptr_q];

  // Requests that cannot be served are dropped
  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == PtrW'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrW'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      count_q <= count_q + CntW'(do_push) - CntW'(do_pop);
    end
  end

endmodule

// ==== hw/recovery_pec.sv ====
`timescale 1ns/1ns
`include "recovery_defines.svh"

module recovery_pec (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                clear_i,
  input  logic                enable_i,
  input  recovery_pkg::byte_t data_i,
  output recovery_pkg::byte_t crc_o
);

  import recovery_pkg::*;

  localparam byte_t Poly = byte_t'(`RECOVERY_PEC_POLY);

  byte_t crc_q;
  byte_t crc_next;

  // Whole byte per cycle, MSB first
  always_comb begin
    crc_next = crc_q ^ data_i;
    for (int i = 0; i < 8; i++) begin
      if (crc_next[7]) begin
        crc_next = {crc_next[6:0], 1'b0} ^ Poly;
      end else begin
        crc_next = {crc_next[6:0], 1'b0};
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni || clear_i) begin
      crc_q <= '0;
    end else if (enable_i) begin
      crc_q <= crc_next;
    end
  end

  assign crc_o = crc_q;

endmodule

// ==== hw/recovery_pkg.sv ====
`include "recovery_defines.svh"

package recovery_pkg;

  // One byte as seen on the bus
  typedef logic [7:0] byte_t;

  // Little-endian packed payload word
  typedef logic [`RECOVERY_WORD_BYTES*8-1:0] word_t;

  // Frame payload length field
  typedef logic [15:0] cmd_len_t;

endpackage

// ==== hw/recovery_receiver.sv ====
`timescale 1ns/1ns
`include "recovery_defines.svh"

module recovery_receiver (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   data_valid_i,
  output logic                   data_ready_o,
  input  recovery_pkg::byte_t    data_data_i,
  output logic                   data_queue_select_o,
  output logic                   data_queue_flush_o,
  input  logic                   data_queue_flow_i,
  input  logic                   bus_start_i,
  input  logic                   bus_stop_i,
  input  recovery_pkg::byte_t    pec_crc_i,
  output logic                   pec_enable_o,
  output logic                   cmd_valid_o,
  output logic                   cmd_is_rd_o,
  output recovery_pkg::byte_t    cmd_cmd_o,
  output recovery_pkg::cmd_len_t cmd_len_o,
  output logic                   cmd_error_o,
  input  logic                   cmd_done_i
);

  import recovery_pkg::*;

  // Low length bits that mark a partial last word
  localparam byte_t LaneMask = byte_t'(`RECOVERY_WORD_BYTES - 1);

  typedef enum logic [3:0] {
    Idle    = 4'h0,
    RxCmd   = 4'h1,
    RxLenL  = 4'h2,
    RxLenH  = 4'h3,
    RxData  = 4'h4,
    RxPec   = 4'h5,
    CmdIsRd = 4'h6,
    Cmd     = 4'h7,
    Busy    = 4'h8
  } state_e;

  state_e   state_q;
  state_e   state_d;
  logic     rx_flow;
  logic     last_byte;
  cmd_len_t dcnt_q;
  byte_t    len_lsb_q;
  byte_t    len_msb_q;
  byte_t    pec_recv_q;
  byte_t    pec_calc_q;

  // Header and PEC bytes are taken directly, payload goes to the queue
  assign data_ready_o = state_q inside {RxCmd, RxLenL, RxLenH, RxPec};
  assign rx_flow      = data_valid_i && data_ready_o;
  assign last_byte    = data_queue_flow_i && (dcnt_q == cmd_len_t'(1));

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      Idle: begin
        if (bus_start_i) begin
          state_d = RxCmd;
        end
      end
      RxCmd: begin
        if (rx_flow) begin
          state_d = RxLenL;
        end else if (bus_stop_i) begin
          state_d = Idle;
        end
      end
      RxLenL: begin
        if (rx_flow) begin
          state_d = RxLenH;
        end else if (bus_stop_i) begin
          state_d = Idle;
        end
      end
      RxLenH: begin
        // Zero length skips the payload phase
        if (rx_flow) begin
          state_d = ({data_data_i, len_lsb_q} == '0) ? RxPec : RxData;
        end else if (bus_start_i) begin
          state_d = CmdIsRd;
        end else if (bus_stop_i) begin
          state_d = Idle;
        end
      end
      RxData: begin
        if (last_byte) begin
          state_d = RxPec;
        end else if (bus_stop_i) begin
          state_d = Idle;
        end
      end
      RxPec: begin
        if (rx_flow) begin
          state_d = Cmd;
        end else if (bus_stop_i) begin
          state_d = Idle;
        end
      end
      CmdIsRd: state_d = Cmd;
      Cmd:     state_d = Busy;
      Busy: begin
        if (cmd_done_i) begin
          state_d = Idle;
        end
      end
      default: state_d = Idle;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q             <= Idle;
      data_queue_select_o <= 1'b1;
      data_queue_flush_o  <= 1'b0;
      cmd_valid_o         <= 1'b0;
      cmd_is_rd_o         <= 1'b0;
      dcnt_q              <= '0;
    end else begin
      state_q             <= state_d;
      // Queue owns the stream only during the payload
      data_queue_select_o <= (state_d != RxData);
      data_queue_flush_o  <= (state_q == Cmd) && |(len_lsb_q & LaneMask);
      cmd_valid_o         <= (state_q == Cmd);
      if (state_q == CmdIsRd) begin
        cmd_is_rd_o <= 1'b1;
      end else if (state_q == Idle) begin
        cmd_is_rd_o <= 1'b0;
      end
      if (state_q == RxLenL && rx_flow) begin
        dcnt_q[7:0] <= data_data_i;
      end else if (state_q == RxLenH && rx_flow) begin
        dcnt_q[15:8] <= data_data_i;
      end else if (state_q == RxData && data_queue_flow_i) begin
        dcnt_q <= dcnt_q - 1'b1;
      end
    end
  end

  // Header fields and PEC values
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      cmd_cmd_o  <= '0;
      len_lsb_q  <= '0;
      len_msb_q  <= '0;
      pec_recv_q <= '0;
      pec_calc_q <= '0;
    end else begin
      unique case (state_q)
        RxCmd: begin
          if (rx_flow) begin
            cmd_cmd_o <= data_data_i;
          end
        end
        RxLenL: begin
          // CRC so far covers the command byte only, which is what a read checks
          if (rx_flow) begin
            len_lsb_q  <= data_data_i;
            pec_calc_q <= pec_crc_i;
          end
        end
        RxLenH: begin
          if (rx_flow) begin
            len_msb_q <= data_data_i;
          end
        end
        RxPec: begin
          if (rx_flow) begin
            pec_recv_q <= data_data_i;
            pec_calc_q <= pec_crc_i;
          end
        end
        CmdIsRd: begin
          // Byte in the length slot was really the PEC
          len_lsb_q  <= '0;
          len_msb_q  <= '0;
          pec_recv_q <= len_lsb_q;
        end
        default: begin
          len_lsb_q <= len_lsb_q;
        end
      endcase
    end
  end

  assign pec_enable_o = data_queue_select_o ? rx_flow : data_queue_flow_i;
  assign cmd_len_o    = {len_msb_q, len_lsb_q};
  assign cmd_error_o  = (pec_calc_q != pec_recv_q);

endmodule

// ==== hw/recovery_rx_top.sv ====
`timescale 1ns/1ns
`include "recovery_defines.svh"

module recovery_rx_top (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   rx_valid_i,
  output logic                   rx_ready_o,
  input  recovery_pkg::byte_t    rx_data_i,
  input  logic                   bus_start_i,
  input  logic                   bus_stop_i,
  output logic                   word_valid_o,
  input  logic                   word_ready_i,
  output recovery_pkg::word_t    word_data_o,
  output logic                   cmd_valid_o,
  output logic                   cmd_is_rd_o,
  output recovery_pkg::byte_t    cmd_o,
  output recovery_pkg::cmd_len_t cmd_len_o,
  output logic                   cmd_error_o,
  input  logic                   cmd_done_i
);

  import recovery_pkg::*;

  byte_t byte_head;
  word_t packed_word;
  logic  byte_full;
  logic  byte_empty;
  logic  byte_pop;
  logic  word_full;
  logic  word_empty;
  logic  word_push;
  logic  queue_select;
  logic  queue_flush;
  logic  queue_flow;
  logic  recv_valid;
  logic  recv_ready;
  logic  pack_valid;
  logic  pack_ready;
  logic  pec_enable;
  byte_t pec_crc;

  // Head of the byte FIFO goes either to the receiver or to the packer
  assign recv_valid = !byte_empty && queue_select;
  assign pack_valid = !byte_empty && !queue_select;
  assign queue_flow = pack_valid && pack_ready;
  assign byte_pop   = (recv_valid && recv_ready) || queue_flow;

  assign rx_ready_o   = !byte_full;
  assign word_valid_o = !word_empty;

  recovery_fifo #(
    .payload_t (byte_t),
    .Depth     (`RECOVERY_BYTE_FIFO_DEPTH)
  ) u_byte_fifo (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (rx_valid_i),
    .data_i  (rx_data_i),
    .pop_i   (byte_pop),
    .full_o  (byte_full),
    .empty_o (byte_empty),
    .data_o  (byte_head)
  );

  recovery_receiver u_receiver (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .data_valid_i        (recv_valid),
    .data_ready_o        (recv_ready),
    .data_data_i         (byte_head),
    .data_queue_select_o (queue_select),
    .data_queue_flush_o  (queue_flush),
    .data_queue_flow_i   (queue_flow),
    .bus_start_i         (bus_start_i),
    .bus_stop_i          (bus_stop_i),
    .pec_crc_i           (pec_crc),
    .pec_enable_o        (pec_enable),
    .cmd_valid_o         (cmd_valid_o),
    .cmd_is_rd_o         (cmd_is_rd_o),
    .cmd_cmd_o           (cmd_o),
    .cmd_len_o           (cmd_len_o),
    .cmd_error_o         (cmd_error_o),
    .cmd_done_i          (cmd_done_i)
  );

  recovery_pec u_pec (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .clear_i  (bus_start_i),
    .enable_i (pec_enable),
    .data_i   (byte_head),
    .crc_o    (pec_crc)
  );

  recovery_word_packer u_packer (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .byte_valid_i (pack_valid),
    .byte_ready_o (pack_ready),
    .byte_i       (byte_head),
    .flush_i      (queue_flush),
    .word_full_i  (word_full),
    .word_push_o  (word_push),
    .word_o       (packed_word)
  );

  recovery_fifo #(
    .payload_t (word_t),
    .Depth     (`RECOVERY_WORD_FIFO_DEPTH)
  ) u_word_fifo (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (word_push),
    .data_i  (packed_word),
    .pop_i   (word_ready_i),
    .full_o  (word_full),
    .empty_o (word_empty),
    .data_o  (word_data_o)
  );

endmodule

// ==== hw/recovery_word_packer.sv ====
`timescale 1ns/1ns
`include "recovery_defines.svh"

module recovery_word_packer (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                byte_valid_i,
  output logic                byte_ready_o,
  input  recovery_pkg::byte_t byte_i,
  input  logic                flush_i,
  input  logic                word_full_i,
  output logic                word_push_o,
  output recovery_pkg::word_t word_o
);

  import recovery_pkg::*;

  localparam int unsigned LaneW = $clog2(`RECOVERY_WORD_BYTES);

  word_t             asm_q;
  word_t             lane_byte;
  logic  [LaneW-1:0] lane_q;
  logic              flush_pend_q;
  logic              flush_req;
  logic              take;
  logic              full_push;
  logic              flush_push;

  // Flush waits here while the word FIFO is full
  assign flush_req    = flush_i || flush_pend_q;
  assign byte_ready_o = !word_full_i && !flush_req;
  assign take         = byte_valid_i && byte_ready_o;

  // First byte lands in the lowest lane
  assign lane_byte = word_t'(byte_i) << {lane_q, 3'b000};

  assign full_push   = take && (lane_q == LaneW'(`RECOVERY_WORD_BYTES - 1));
  assign flush_push  = flush_req && !word_full_i && (lane_q != '0);
  assign word_push_o = full_push || flush_push;
  assign word_o      = full_push ? (asm_q | lane_byte) : asm_q;

  // Unfilled lanes stay zero, so a flushed word comes out padded
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      asm_q        <= '0;
      lane_q       <= '0;
      flush_pend_q <= 1'b0;
    end else begin
      if (word_push_o) begin
        asm_q  <= '0;
        lane_q <= '0;
      end else if (take) begin
        asm_q  <= asm_q | lane_byte;
        lane_q <= lane_q + 1'b1;
      end
      if (flush_req) begin
        flush_pend_q <= word_full_i && (lane_q != '0);
      end
    end
  end

endmodule

// ==== recovery_rx_top.f ====
+incdir+hw
hw/recovery_pkg.sv
hw/recovery_fifo.sv
hw/recovery_pec.sv
hw/recovery_receiver.sv
hw/recovery_word_packer.sv
hw/recovery_rx_top.sv
tb/recovery_rx_tb.sv

// ==== tb/recovery_rx_tb.sv ====
`timescale 1ns/1ns
`include "recovery_defines.svh"

module recovery_rx_tb;

  import recovery_pkg::*;

  localparam int unsigned MaxWait = 2000;

  logic     clk;
  logic     rst_n;
  logic     rx_valid;
  logic     rx_ready;
  byte_t    rx_data;
  logic     bus_start;
  logic     bus_stop;
  logic     word_valid;
  logic     word_ready;
  word_t    word_data;
  logic     cmd_valid;
  logic     cmd_is_rd;
  byte_t    cmd;
  cmd_len_t cmd_len;
  logic     cmd_error;
  logic     cmd_done;

  logic [31:0] lfsr_q;
  logic        gaps_on;
  word_t       exp_words[$];
  byte_t       payload_q[$];

  always #2 clk = ~clk;

  recovery_rx_top DUT (
    .clk_i        (clk),
    .rst_ni       (rst_n),
    .rx_valid_i   (rx_valid),
    .rx_ready_o   (rx_ready),
    .rx_data_i    (rx_data),
    .bus_start_i  (bus_start),
    .bus_stop_i   (bus_stop),
    .word_valid_o (word_valid),
    .word_ready_i (word_ready),
    .word_data_o  (word_data),
    .cmd_valid_o  (cmd_valid),
    .cmd_is_rd_o  (cmd_is_rd),
    .cmd_o        (cmd),
    .cmd_len_o    (cmd_len),
    .cmd_error_o  (cmd_error),
    .cmd_done_i   (cmd_done)
  );

  // Galois form, taps 32 22 2 1
  function automatic logic rand_bit();
    logic lsb;
    lsb    = lfsr_q[0];
    lfsr_q = lfsr_q >> 1;
    if (lsb) begin
      lfsr_q = lfsr_q ^ 32'h8020_0003;
    end
    return lsb;
  endfunction

  function automatic int unsigned rand_bits(int unsigned n);
    int unsigned v;
    v = 0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], rand_bit()};
    end
    return v;
  endfunction

  function automatic void make_payload(int unsigned len);
    payload_q.delete();
    for (int i = 0; i < len; i++) begin
      payload_q.push_back(byte_t'(rand_bits(8)));
    end
  endfunction

  // CRC-8, zero start, MSB first
  function automatic byte_t crc8(byte_t bytes[$]);
    byte_t c;
    c = '0;
    foreach (bytes[i]) begin
      c = c ^ bytes[i];
      for (int b = 0; b < 8; b++) begin
        c = c[7] ? ((c << 1) ^ byte_t'(`RECOVERY_PEC_POLY)) : (c << 1);
      end
    end
    return c;
  endfunction

  // Little-endian words, last one zero padded
  function automatic void expect_words(byte_t bytes[$]);
    word_t       w;
    int unsigned lane;
    w    = '0;
    lane = 0;
    foreach (bytes[i]) begin
      w[lane*8 +: 8] = bytes[i];
      lane++;
      if (lane == `RECOVERY_WORD_BYTES) begin
        exp_words.push_back(w);
        w    = '0;
        lane = 0;
      end
    end
    if (lane != 0) begin
      exp_words.push_back(w);
    end
  endfunction

  task automatic abort_run();
    $display("Errors found");
    $fatal(1);
  endtask

  task automatic check_word(string name, word_t got, word_t exp);
    if (got !== exp) begin
      $display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_byte(string name, byte_t got, byte_t exp);
    if (got !== exp) begin
      $display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_len(string name, cmd_len_t got, cmd_len_t exp);
    if (got !== exp) begin
      $display("error at %0t: %s is %h, expected %h", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_flag(string name, logic got, logic exp);
    if (got !== exp) begin
      $display("error at %0t: %s is %b, expected %b", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic bus_event(logic start, logic stop);
    bus_start = start;
    bus_stop  = stop;
    next_cycle();
    bus_start = 1'b0;
    bus_stop  = 1'b0;
  endtask

  task automatic send_byte(byte_t b);
    int unsigned n;
    n        = 0;
    rx_valid = 1'b1;
    rx_data  = b;
    while (!rx_ready) begin
      next_cycle();
      n++;
      if (n > MaxWait) begin
        $display("Timeout waiting for the byte FIFO to accept a byte");
        abort_run();
      end
    end
    next_cycle();
    rx_valid = 1'b0;
  endtask

  // Checks the command fields, then hands the receiver back with done
  task automatic wait_cmd(byte_t c, cmd_len_t len, logic is_rd, logic err);
    int unsigned n;
    n = 0;
    while (!cmd_valid) begin
      next_cycle();
      n++;
      if (n > MaxWait) begin
        $display("Timeout waiting for a command from the receiver");
        abort_run();
      end
    end
    check_byte("cmd_o", cmd, c);
    check_len("cmd_len_o", cmd_len, len);
    check_flag("cmd_is_rd_o", cmd_is_rd, is_rd);
    check_flag("cmd_error_o", cmd_error, err);
    cmd_done = 1'b1;
    next_cycle();
    cmd_done = 1'b0;
  endtask

  task automatic wait_words_drained();
    int unsigned n;
    n = 0;
    while (exp_words.size() != 0) begin
      next_cycle();
      n++;
      if (n > MaxWait) begin
        $display("Timeout with %0d expected words not delivered", exp_words.size());
        abort_run();
      end
    end
  endtask

  task automatic send_write(byte_t c, byte_t payload[$], logic bad_pec);
    byte_t frame[$];
    byte_t pec;
    frame = {c, byte_t'(payload.size()), byte_t'(payload.size() >> 8)};
    foreach (payload[i]) begin
      frame.push_back(payload[i]);
    end
    pec = crc8(frame) ^ (bad_pec ? 8'h5a : 8'h00);
    frame.push_back(pec);
    expect_words(payload);
    bus_event(1'b1, 1'b0);
    foreach (frame[i]) begin
      send_byte(frame[i]);
    end
    wait_cmd(c, cmd_len_t'(payload.size()), 1'b0, bad_pec);
    bus_event(1'b0, 1'b1);
    wait_words_drained();
  endtask

  task automatic send_read(byte_t c, logic bad_pec);
    byte_t one[$];
    byte_t pec;
    one = {c};
    pec = crc8(one) ^ (bad_pec ? 8'h3c : 8'h00);
    bus_event(1'b1, 1'b0);
    send_byte(c);
    send_byte(pec);
    // Let the receiver take the PEC before the repeated start
    repeat (3) next_cycle();
    bus_event(1'b1, 1'b0);
    wait_cmd(c, '0, 1'b1, bad_pec);
    bus_event(1'b0, 1'b1);
  endtask

  task automatic send_aborted(byte_t c, cmd_len_t len);
    bus_event(1'b1, 1'b0);
    send_byte(c);
    send_byte(len[7:0]);
    send_byte(len[15:8]);
    repeat (3) next_cycle();
    bus_event(1'b0, 1'b1);
    for (int i = 0; i < 50; i++) begin
      if (cmd_valid) begin
        $display("A command was reported for an aborted frame");
        abort_run();
      end
      next_cycle();
    end
  endtask

  // Word compare, a word moves on the next edge when valid and ready
  always @(negedge clk) begin : word_check
    word_t exp_word;
    if (rst_n && word_valid && word_ready) begin
      if (exp_words.size() == 0) begin
        $display("Word %h came out with no word expected", word_data);
        abort_run();
      end else begin
        exp_word = exp_words.pop_front();
        check_word("word_data_o", word_data, exp_word);
      end
    end
  end

  // Sink takes a word about one cycle in eight, so both FIFOs fill up
  always @(posedge clk) begin
    #1;
    word_ready = gaps_on ? (rand_bits(3) == 0) : 1'b1;
  end

  initial begin
    lfsr_q     = 32'hfe73_338d;
    clk        = 1'b0;
    rst_n      = 1'b0;
    rx_valid   = 1'b0;
    rx_data    = '0;
    bus_start  = 1'b0;
    bus_stop   = 1'b0;
    word_ready = 1'b1;
    cmd_done   = 1'b0;
    gaps_on    = 1'b0;
    repeat (4) @(posedge clk);
    #1;
    rst_n = 1'b1;
    next_cycle();
    check_flag("rx_ready_o", rx_ready, 1'b1);
    check_flag("cmd_valid_o", cmd_valid, 1'b0);
    check_flag("word_valid_o", word_valid, 1'b0);

    make_payload(8);
    send_write(8'h26, payload_q, 1'b0);

    make_payload(5);
    send_write(8'h27, payload_q, 1'b0);
    make_payload(7);
    send_write(8'h28, payload_q, 1'b0);
    make_payload(rand_bits(4) + 1);
    send_write(byte_t'(rand_bits(8)), payload_q, 1'b0);

    make_payload(6);
    send_write(8'h29, payload_q, 1'b1);

    send_read(8'h2a, 1'b0);
    send_read(8'h2b, 1'b1);

    send_aborted(8'h2c, 16'd12);
    make_payload(3);
    send_write(8'h2d, payload_q, 1'b0);

    // Long write with a stalling sink, partial last word flushed under stall
    make_payload(42);
    gaps_on = 1'b1;
    send_write(8'h2e, payload_q, 1'b0);
    gaps_on = 1'b0;
    next_cycle();

    $display("No errors");
    $finish;
  end

endmodule
